// File: hw/addr_decode.sv
`timescale 1ns/1ps
`include "laser_bus_consts.svh"

module addr_decode (
	input  laser_bus_pkg::cpu_addr_t   cpu_addr_i,
	output laser_bus_pkg::bus_region_t region_o,
	output logic                       shrg_port_o
);

	logic [4:0] a_hi;	// 2 KB block number

	assign a_hi = cpu_addr_i[15:11];

	// 0000-67FF ROMs, not fitted here
	// 6800-6FFF keyboard read and output latch
	// 7000-77FF video RAM
	// 7800-B7FF base RAM
	// B800-FFFF expansion, not fitted
	always_comb
	begin
		if (a_hi == 5'b01101)
			region_o = laser_bus_pkg::REGION_KEY_IO;
		else if (a_hi == 5'b01110)
			region_o = laser_bus_pkg::REGION_VRAM;
		else if (a_hi inside {[5'b01111:5'b10110]})
			region_o = laser_bus_pkg::REGION_RAM;
		else
			region_o = laser_bus_pkg::REGION_UNMAPPED;
	end

	// Z80 I/O uses only the low address byte
	assign shrg_port_o = (cpu_addr_i[7:0] == 8'(`LB_SHRG_PORT));

endmodule

// File: hw/bus_phase_gen.sv
`timescale 1ns/1ps
`include "laser_bus_consts.svh"

module bus_phase_gen (
	input  logic CLK50MHZ,
	input  logic RESET_N,
	input  logic turbo_i,
	output logic cpu_clk_o,
	output logic wr_commit_o,
	output logic latch_o
);

	laser_bus_pkg::seq_phase_t phase;
	logic [3:0] wait_cnt;	// Clocks left in PH_WAIT

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			phase       <= laser_bus_pkg::PH_STROBE;
			wait_cnt    <= 4'd0;
			cpu_clk_o   <= 1'b0;
			wr_commit_o <= 1'b0;
			latch_o     <= 1'b0;
		end
		else
		begin
			case (phase)
				laser_bus_pkg::PH_STROBE:
				begin
					cpu_clk_o <= 1'b1;	// One clock wide
					phase     <= laser_bus_pkg::PH_LATCH;
				end
				laser_bus_pkg::PH_LATCH:
				begin
					// Bus inputs have settled here, commit writes and latch data
					cpu_clk_o   <= 1'b0;
					wr_commit_o <= 1'b1;
					latch_o     <= 1'b1;
					phase       <= laser_bus_pkg::PH_SETTLE;
				end
				laser_bus_pkg::PH_SETTLE:
				begin
					wr_commit_o <= 1'b0;
					latch_o     <= 1'b0;
					// Three phases already spent plus the final wait clock
					if (turbo_i)
						wait_cnt <= 4'(`LB_TURBO_CYCLES - 4);
					else
						wait_cnt <= 4'(`LB_NORMAL_CYCLES - 4);
					phase <= laser_bus_pkg::PH_WAIT;
				end
				default:
				begin
					if (wait_cnt == 4'd0)
						phase <= laser_bus_pkg::PH_STROBE;
					else
						wait_cnt <= wait_cnt - 4'd1;
				end
			endcase
		end
	end

endmodule

// File: hw/key_matrix.sv
`timescale 1ns/1ps
`include "laser_bus_consts.svh"

module key_matrix (
	input  logic                     CLK50MHZ,
	input  logic                     RESET_N,
	input  logic                     key_strobe_i,
	input  logic                     key_pressed_i,
	input  laser_bus_pkg::bus_byte_t key_code_i,
	input  laser_bus_pkg::cpu_addr_t cpu_addr_i,
	input  logic                     cass_in_i,
	output laser_bus_pkg::bus_byte_t key_byte_o
);

	laser_bus_pkg::key_mat_t key_mat;
	laser_bus_pkg::key_ex_t  key_ex;
	laser_bus_pkg::key_mat_t key_eff;	// Matrix with extended keys folded in
	logic                    key_n;		// Level stored for this event
	logic                    ctrl_free;
	logic [5:0]              key_col;

	assign key_n = ~key_pressed_i;

	// Left and Backspace share key_ex[3], both are Ctrl+M
	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			key_mat <= '1;
			key_ex  <= '1;
		end
		else if (key_strobe_i)
		begin
			case (key_code_i)
				8'h16: key_mat[28] <= key_n;	// 1
				8'h1E: key_mat[25] <= key_n;	// 2
				8'h26: key_mat[27] <= key_n;	// 3
				8'h25: key_mat[29] <= key_n;	// 4
				8'h2E: key_mat[24] <= key_n;	// 5
				8'h36: key_mat[40] <= key_n;	// 6
				8'h3D: key_mat[45] <= key_n;	// 7
				8'h3E: key_mat[43] <= key_n;	// 8
				8'h46: key_mat[41] <= key_n;	// 9
				8'h45: key_mat[44] <= key_n;	// 0
				8'h4E: key_mat[42] <= key_n;	// Minus
				8'h49: key_mat[33] <= key_n;	// Period
				8'h41: key_mat[35] <= key_n;	// Comma
				8'h4C: key_mat[60] <= key_n;	// Semicolon
				8'h52: key_mat[58] <= key_n;	// Quote reads as colon
				8'h5A: key_mat[50] <= key_n;	// Return
				8'h29: key_mat[36] <= key_n;	// Space
				8'h15: key_mat[4]  <= key_n;	// Q
				8'h1D: key_mat[1]  <= key_n;	// W
				8'h24: key_mat[3]  <= key_n;	// E
				8'h2D: key_mat[5]  <= key_n;	// R
				8'h2C: key_mat[0]  <= key_n;	// T
				8'h35: key_mat[48] <= key_n;	// Y
				8'h3C: key_mat[53] <= key_n;	// U
				8'h43: key_mat[51] <= key_n;	// I
				8'h44: key_mat[49] <= key_n;	// O
				8'h4D: key_mat[52] <= key_n;	// P
				8'h1C: key_mat[12] <= key_n;	// A
				8'h1B: key_mat[9]  <= key_n;	// S
				8'h23: key_mat[11] <= key_n;	// D
				8'h2B: key_mat[13] <= key_n;	// F
				8'h34: key_mat[8]  <= key_n;	// G
				8'h33: key_mat[56] <= key_n;	// H
				8'h3B: key_mat[61] <= key_n;	// J
				8'h42: key_mat[59] <= key_n;	// K
				8'h4B: key_mat[57] <= key_n;	// L
				8'h1A: key_mat[20] <= key_n;	// Z
				8'h22: key_mat[17] <= key_n;	// X
				8'h21: key_mat[19] <= key_n;	// C
				8'h2A: key_mat[21] <= key_n;	// V
				8'h32: key_mat[16] <= key_n;	// B
				8'h31: key_mat[32] <= key_n;	// N
				8'h3A: key_mat[37] <= key_n;	// M
				8'h14: key_mat[10] <= key_n;	// Either Ctrl
				8'h12: key_mat[18] <= key_n;	// Left Shift
				8'h59: key_ex[0]   <= key_n;	// Right Shift
				8'h76: key_ex[1]   <= key_n;	// Esc
				8'h75: key_ex[2]   <= key_n;	// Up
				8'h6B: key_ex[3]   <= key_n;	// Left
				8'h66: key_ex[3]   <= key_n;	// Backspace
				8'h74: key_ex[4]   <= key_n;	// Right
				8'h72: key_ex[5]   <= key_n;	// Down
				default: ;
			endcase
		end
	end

	// Cursor keys, Esc and Backspace also hold Ctrl down
	assign ctrl_free = &key_ex[5:1];

	always_comb
	begin
		key_eff     = key_mat;
		key_eff[18] = key_mat[18] & key_ex[0];	// Shift
		key_eff[42] = key_mat[42] & key_ex[1];	// Ctrl+- is Esc
		key_eff[33] = key_mat[33] & key_ex[2];	// Ctrl+. is Up
		key_eff[37] = key_mat[37] & key_ex[3];	// Ctrl+M is Left
		key_eff[35] = key_mat[35] & key_ex[4];	// Ctrl+, is Right
		key_eff[36] = key_mat[36] & key_ex[5];	// Ctrl+Space is Down
		key_eff[10] = key_mat[10] & ctrl_free;

		// Rows are selected by low address bits at 0
		for (int b = 0; b < 6; b++)
		begin
			key_col[b] = 1'b1;
			for (int r = 0; r < 8; r++)
				key_col[b] = key_col[b] & (cpu_addr_i[r] | key_eff[r*8 + b]);
		end
	end

	assign key_byte_o = {`LB_KEY_BIT7, ~cass_in_i, key_col};

endmodule

// File: hw/laser_bus_pkg.sv
package laser_bus_pkg;

	// Z80 address and data
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  bus_byte_t;

	// Key matrix, index row*8+column, 0 means pressed
	// Columns 6 and 7 of each row are not wired
	typedef logic [63:0] key_mat_t;

	// Extended PS/2 keys, active low
	// 0 right Shift, 1 Esc, 2 Up, 3 Left and Backspace, 4 Right, 5 Down
	typedef logic [5:0]  key_ex_t;

	// Memory map regions seen by the CPU
	typedef enum logic [1:0] {
		REGION_UNMAPPED,
		REGION_KEY_IO,
		REGION_VRAM,
		REGION_RAM
	} bus_region_t;

	// Bus-cycle sequencer phases
	typedef enum logic [1:0] {
		PH_STROBE,
		PH_LATCH,
		PH_SETTLE,
		PH_WAIT
	} seq_phase_t;

endpackage

// File: hw/laser_bus_top.sv
`timescale 1ns/1ps

module laser_bus_top (
	input  logic                     CLK50MHZ,
	input  logic                     RESET_N,
	input  logic                     turbo_i,
	input  laser_bus_pkg::cpu_addr_t cpu_addr_i,
	input  laser_bus_pkg::bus_byte_t cpu_dout_i,
	input  logic                     cpu_mreq_i,
	input  logic                     cpu_iorq_i,
	input  logic                     cpu_rd_i,	// Any cycle without WR reads
	input  logic                     cpu_wr_i,
	output laser_bus_pkg::bus_byte_t cpu_din_o,
	output logic                     cpu_clk_o,
	input  logic                     key_strobe_i,
	input  logic                     key_pressed_i,
	input  laser_bus_pkg::bus_byte_t key_code_i,
	input  logic                     cass_in_i,
	output logic                     ag_o,
	output logic                     css_o,
	output logic                     cass_o,
	output logic [1:0]               speaker_o,
	output logic [2:0]               gm_o
);

	logic                       wr_commit;
	logic                       latch;
	laser_bus_pkg::bus_region_t region;
	logic                       shrg_port;
	laser_bus_pkg::bus_byte_t   vram_q;
	laser_bus_pkg::bus_byte_t   ram_q;
	laser_bus_pkg::bus_byte_t   key_byte;

	bus_phase_gen i_phase (
		.CLK50MHZ    (CLK50MHZ),
		.RESET_N     (RESET_N),
		.turbo_i     (turbo_i),
		.cpu_clk_o   (cpu_clk_o),
		.wr_commit_o (wr_commit),
		.latch_o     (latch)
	);

	addr_decode i_decode (
		.cpu_addr_i  (cpu_addr_i),
		.region_o    (region),
		.shrg_port_o (shrg_port)
	);

	mem_io_exec i_mem_io (
		.CLK50MHZ    (CLK50MHZ),
		.RESET_N     (RESET_N),
		.cpu_addr_i  (cpu_addr_i),
		.cpu_dout_i  (cpu_dout_i),
		.cpu_mreq_i  (cpu_mreq_i),
		.cpu_iorq_i  (cpu_iorq_i),
		.cpu_wr_i    (cpu_wr_i),
		.wr_commit_i (wr_commit),
		.latch_i     (latch),
		.region_i    (region),
		.shrg_port_i (shrg_port),
		.vram_q_o    (vram_q),
		.ram_q_o     (ram_q),
		.ag_o        (ag_o),
		.css_o       (css_o),
		.cass_o      (cass_o),
		.speaker_o   (speaker_o),
		.gm_o        (gm_o)
	);

	key_matrix i_keys (
		.CLK50MHZ      (CLK50MHZ),
		.RESET_N       (RESET_N),
		.key_strobe_i  (key_strobe_i),
		.key_pressed_i (key_pressed_i),
		.key_code_i    (key_code_i),
		.cpu_addr_i    (cpu_addr_i),
		.cass_in_i     (cass_in_i),
		.key_byte_o    (key_byte)
	);

	read_select i_rdsel (
		.CLK50MHZ   (CLK50MHZ),
		.RESET_N    (RESET_N),
		.latch_i    (latch),
		.region_i   (region),
		.key_byte_i (key_byte),
		.vram_q_i   (vram_q),
		.ram_q_i    (ram_q),
		.cpu_din_o  (cpu_din_o)
	);

endmodule

// File: hw/mem_io_exec.sv
`timescale 1ns/1ps
`include "laser_bus_consts.svh"

module mem_io_exec (
	input  logic                       CLK50MHZ,
	input  logic                       RESET_N,
	input  laser_bus_pkg::cpu_addr_t   cpu_addr_i,
	input  laser_bus_pkg::bus_byte_t   cpu_dout_i,
	input  logic                       cpu_mreq_i,
	input  logic                       cpu_iorq_i,
	input  logic                       cpu_wr_i,
	input  logic                       wr_commit_i,
	input  logic                       latch_i,
	input  laser_bus_pkg::bus_region_t region_i,
	input  logic                       shrg_port_i,
	output laser_bus_pkg::bus_byte_t   vram_q_o,
	output laser_bus_pkg::bus_byte_t   ram_q_o,
	output logic                       ag_o,
	output logic                       css_o,
	output logic                       cass_o,
	output logic [1:0]                 speaker_o,
	output logic [2:0]                 gm_o
);

	laser_bus_pkg::bus_byte_t vram [2**`LB_VRAM_AW];
	laser_bus_pkg::bus_byte_t ram  [2**`LB_RAM_AW];

	laser_bus_pkg::bus_byte_t io_latch;
	laser_bus_pkg::bus_byte_t shrg_reg;

	logic mem_wr;
	logic io_wr;

	logic [`LB_VRAM_AW-1:0] vram_idx;
	logic [`LB_RAM_AW-1:0]  ram_idx;

	assign mem_wr = cpu_mreq_i & cpu_wr_i & ~cpu_iorq_i;
	assign io_wr  = cpu_iorq_i & cpu_wr_i;

	assign vram_idx = cpu_addr_i[`LB_VRAM_AW-1:0];
	assign ram_idx  = cpu_addr_i[`LB_RAM_AW-1:0];	// 7800 folds onto 3800

	// Video RAM, read before write
	always_ff @(posedge CLK50MHZ)
	begin
		if (wr_commit_i && mem_wr && region_i == laser_bus_pkg::REGION_VRAM)
			vram[vram_idx] <= cpu_dout_i;
		vram_q_o <= vram[vram_idx];
	end

	// Base RAM
	always_ff @(posedge CLK50MHZ)
	begin
		if (wr_commit_i && mem_wr && region_i == laser_bus_pkg::REGION_RAM)
			ram[ram_idx] <= cpu_dout_i;
		ram_q_o <= ram[ram_idx];
	end

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			io_latch <= `LB_IO_LATCH_RESET;
			shrg_reg <= `LB_SHRG_RESET;
		end
		else if (latch_i)
		begin
			if (mem_wr && region_i == laser_bus_pkg::REGION_KEY_IO)
				io_latch <= cpu_dout_i;
			if (io_wr && shrg_port_i)
				shrg_reg <= cpu_dout_i;
		end
	end

	assign ag_o      = io_latch[3];	// Graphics mode to the VDG
	assign css_o     = io_latch[4];
	assign cass_o    = io_latch[2];
	assign speaker_o = {io_latch[0], io_latch[5]};	// Speaker pair, driven in antiphase
	assign gm_o      = shrg_reg[4:2];

endmodule

// File: hw/read_select.sv
`timescale 1ns/1ps
`include "laser_bus_consts.svh"

module read_select (
	input  logic                       CLK50MHZ,
	input  logic                       RESET_N,
	input  logic                       latch_i,
	input  laser_bus_pkg::bus_region_t region_i,
	input  laser_bus_pkg::bus_byte_t   key_byte_i,
	input  laser_bus_pkg::bus_byte_t   vram_q_i,
	input  laser_bus_pkg::bus_byte_t   ram_q_i,
	output laser_bus_pkg::bus_byte_t   cpu_din_o
);

	laser_bus_pkg::bus_byte_t key_byte_q;

	// Keyboard column byte frozen for the rest of the bus cycle
	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
			key_byte_q <= 8'h00;
		else if (latch_i)
			key_byte_q <= key_byte_i;
	end

	always_comb
	begin
		case (region_i)
			laser_bus_pkg::REGION_KEY_IO: cpu_din_o = key_byte_q;
			laser_bus_pkg::REGION_VRAM:   cpu_din_o = vram_q_i;
			laser_bus_pkg::REGION_RAM:    cpu_din_o = ram_q_i;
			default:                      cpu_din_o = `LB_UNMAPPED_DATA;	// ROM windows too
		endcase
	end

endmodule

// File: include/laser_bus_consts.svh
`ifndef LASER_BUS_CONSTS_SVH
`define LASER_BUS_CONSTS_SVH

// Bus-cycle length in CLK50MHZ clocks
`define LB_NORMAL_CYCLES	14
`define LB_TURBO_CYCLES		4

// Address widths of the on-board RAMs
`define LB_VRAM_AW		11	// 2 KB video RAM at 7000
`define LB_RAM_AW		14	// 16 KB base RAM at 7800

// I/O port of the SHRG graphics-mode register
`define LB_SHRG_PORT		32

// Reset values of the board latches
`define LB_SHRG_RESET		8'h08	// GM field of 2
`define LB_IO_LATCH_RESET	8'h00

// Read value where nothing answers
`define LB_UNMAPPED_DATA	8'hFF

// Top bit of the keyboard byte is never driven low
`define LB_KEY_BIT7		1'b1

`endif

// File: laser_bus.f
+incdir+include
hw/laser_bus_pkg.sv
hw/bus_phase_gen.sv
hw/addr_decode.sv
hw/key_matrix.sv
hw/mem_io_exec.sv
hw/read_select.sv
hw/laser_bus_top.sv
test/bus_checker.sv
test/tb_laser_bus.sv

// File: test/bus_checker.sv
`timescale 1ns/1ps
`include "laser_bus_consts.svh"

module bus_checker (
	input  logic        CLK50MHZ,
	input  logic        RESET_N,
	input  logic        turbo_i,
	input  logic [15:0] cpu_addr_i,
	input  logic [7:0]  cpu_dout_i,
	input  logic        cpu_mreq_i,
	input  logic        cpu_iorq_i,
	input  logic        cpu_rd_i,
	input  logic        cpu_wr_i,
	input  logic [7:0]  cpu_din_i,
	input  logic        cpu_clk_i,
	input  logic        key_strobe_i,
	input  logic        key_pressed_i,
	input  logic [7:0]  key_code_i,
	input  logic        cass_in_i,
	input  logic        ag_i,
	input  logic        css_i,
	input  logic        cass_i,
	input  logic [1:0]  speaker_i,
	input  logic [2:0]  gm_i,
	output int          errors_o,
	output int          checks_o
);

	localparam int N_KEYS = 35;

	// A to Z, Ctrl, Shift, then right Shift, Esc, Up, Left, Backspace, Right, Down
	localparam logic [8*N_KEYS-1:0] KEY_CODE = {
		8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
		8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
		8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A, 8'h14, 8'h12,
		8'h59, 8'h76, 8'h75, 8'h6B, 8'h66, 8'h74, 8'h72};
	// Matrix index row*8+column, 64 and up are extended slots
	localparam logic [7*N_KEYS-1:0] KEY_SLOT = {
		7'd12, 7'd16, 7'd19, 7'd11, 7'd3,  7'd13, 7'd8,  7'd56, 7'd51, 7'd61,
		7'd59, 7'd57, 7'd37, 7'd32, 7'd49, 7'd52, 7'd4,  7'd5,  7'd9,  7'd0,
		7'd53, 7'd21, 7'd1,  7'd17, 7'd48, 7'd20, 7'd10, 7'd18,
		7'd64, 7'd65, 7'd66, 7'd67, 7'd67, 7'd68, 7'd69};
	// Merge targets of slots 69 down to 64
	localparam logic [35:0] EX_TARGET = {6'd36, 6'd35, 6'd37, 6'd33, 6'd42, 6'd18};

	logic [7:0]  mem_model [logic [15:0]];	// VRAM and RAM by CPU address
	logic [7:0]  io_latch;
	logic [7:0]  shrg;
	logic [69:0] key_down;	// 1 while held
	logic        started;
	int          clk_cnt;
	int          last_strobe;

	task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks_o++;
		if (got !== exp)
		begin
			errors_o++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	function automatic logic [7:0] key_col_byte(input logic [15:0] addr, input logic cass);
		logic [63:0] held;
		logic [7:0]  col;
		held = key_down[63:0];
		for (int i = 0; i < 6; i++)
			if (key_down[64 + i])
				held[EX_TARGET[i*6 +: 6]] = 1'b1;
		if (|key_down[69:65])
			held[10] = 1'b1;	// Ctrl rides along with the cursor keys
		col = {1'b1, ~cass, 6'h3F};
		for (int r = 0; r < 8; r++)
			for (int b = 0; b < 6; b++)
				if (!addr[r] && held[r*8 + b])
					col[b] = 1'b0;
		return col;
	endfunction

	task automatic key_update();
		for (int i = 0; i < N_KEYS; i++)
			if (KEY_CODE[i*8 +: 8] == key_code_i)
				key_down[KEY_SLOT[i*7 +: 7]] = key_pressed_i;
	endtask

	// Bus inputs still hold the cycle that is ending
	task automatic end_cycle();
		int  want;
		logic is_mem;
		want = turbo_i ? `LB_TURBO_CYCLES : `LB_NORMAL_CYCLES;
		is_mem = cpu_addr_i >= 16'h7000 && cpu_addr_i <= 16'hB7FF;
		checks_o++;
		if (clk_cnt - last_strobe != want)
		begin
			errors_o++;
			$display("CHECK FAILED at %0t: cpu_clk_o spacing is %0d, expected %0d",
				$time, clk_cnt - last_strobe, want);
		end
		if (cpu_mreq_i && cpu_wr_i && !cpu_iorq_i)
		begin
			if (cpu_addr_i[15:11] == 5'b01101)
				io_latch = cpu_dout_i;
			else if (is_mem)
				mem_model[cpu_addr_i] = cpu_dout_i;
		end
		if (cpu_iorq_i && cpu_wr_i && cpu_addr_i[7:0] == 8'(`LB_SHRG_PORT))
			shrg = cpu_dout_i;
		check("ag_o", ag_i, io_latch[3]);
		check("css_o", css_i, io_latch[4]);
		check("cass_o", cass_i, io_latch[2]);
		check("speaker_o", speaker_i, {io_latch[0], io_latch[5]});
		check("gm_o", gm_i, shrg[4:2]);
		if (cpu_mreq_i && cpu_rd_i)
		begin
			if (cpu_addr_i[15:11] == 5'b01101)
				check("cpu_din_o", cpu_din_i, key_col_byte(cpu_addr_i, cass_in_i));
			else if (is_mem && mem_model.exists(cpu_addr_i))
				check("cpu_din_o", cpu_din_i, mem_model[cpu_addr_i]);
			else if (is_mem)
			begin
				errors_o++;
				$display("Read of address %h that was never written, at %0t", cpu_addr_i, $time);
			end
			else
				check("cpu_din_o", cpu_din_i, `LB_UNMAPPED_DATA);
		end
	endtask

	always @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			mem_model.delete();
			io_latch = 8'h00;
			shrg = `LB_SHRG_RESET;
			key_down = '0;
			started = 1'b0;
			clk_cnt = 0;
			last_strobe = 0;
			errors_o = 0;
			checks_o = 0;
		end
		else
		begin
			clk_cnt++;
			if (key_strobe_i)
				key_update();
			if (cpu_clk_i)
			begin
				if (started)
					end_cycle();
				started = 1'b1;
				last_strobe = clk_cnt;
			end
		end
	end

endmodule

// File: test/tb_laser_bus.sv
`timescale 1ns/1ps
`include "laser_bus_consts.svh"

module tb_laser_bus;

	localparam int N_KEYS = 35;

	// Letters, Ctrl, Shift, then the extended keys
	localparam logic [8*N_KEYS-1:0] KEY_CODES = {
		8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
		8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
		8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A, 8'h14, 8'h12,
		8'h59, 8'h76, 8'h75, 8'h6B, 8'h66, 8'h74, 8'h72};

	logic        CLK50MHZ;
	logic        RESET_N;
	logic        turbo_i;
	logic [15:0] cpu_addr_i;
	logic [7:0]  cpu_dout_i;
	logic        cpu_mreq_i;
	logic        cpu_iorq_i;
	logic        cpu_rd_i;
	logic        cpu_wr_i;
	logic [7:0]  cpu_din_o;
	logic        cpu_clk_o;
	logic        key_strobe_i;
	logic        key_pressed_i;
	logic [7:0]  key_code_i;
	logic        cass_in_i;
	logic        ag_o;
	logic        css_o;
	logic        cass_o;
	logic [1:0]  speaker_o;
	logic [2:0]  gm_o;

	int          errors;
	int          checks;
	int          failed_tests;
	logic [31:0] rng;
	logic        hung;	// Set once a strobe wait timed out
	logic [15:0] written [$];

	laser_bus_top i_dut (.*);

	bus_checker i_chk (
		.CLK50MHZ      (CLK50MHZ),
		.RESET_N       (RESET_N),
		.turbo_i       (turbo_i),
		.cpu_addr_i    (cpu_addr_i),
		.cpu_dout_i    (cpu_dout_i),
		.cpu_mreq_i    (cpu_mreq_i),
		.cpu_iorq_i    (cpu_iorq_i),
		.cpu_rd_i      (cpu_rd_i),
		.cpu_wr_i      (cpu_wr_i),
		.cpu_din_i     (cpu_din_o),
		.cpu_clk_i     (cpu_clk_o),
		.key_strobe_i  (key_strobe_i),
		.key_pressed_i (key_pressed_i),
		.key_code_i    (key_code_i),
		.cass_in_i     (cass_in_i),
		.ag_i          (ag_o),
		.css_i         (css_o),
		.cass_i        (cass_o),
		.speaker_i     (speaker_o),
		.gm_i          (gm_o),
		.errors_o      (errors),
		.checks_o      (checks)
	);

	always #10 CLK50MHZ = ~CLK50MHZ;

	function automatic logic [31:0] xorshift32();
		rng ^= rng << 13;
		rng ^= rng >> 17;
		rng ^= rng << 5;
		return rng;
	endfunction

	// Returns at the edge that ends a bus cycle
	task automatic wait_strobe();
		int n;
		n = 0;
		while (!hung)
		begin
			@(posedge CLK50MHZ);
			if (cpu_clk_o)
				break;
			n++;
			if (n > 40)
			begin
				$display("Timeout: no cpu_clk_o strobe within 40 clocks at %0t", $time);
				hung = 1'b1;
			end
		end
	endtask

	task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] data,
		input logic mreq, input logic iorq, input logic rd, input logic wr, input logic cass);
		wait_strobe();
		cpu_addr_i <= addr;
		cpu_dout_i <= data;
		cpu_mreq_i <= mreq;
		cpu_iorq_i <= iorq;
		cpu_rd_i   <= rd;
		cpu_wr_i   <= wr;
		cass_in_i  <= cass;
	endtask

	// One key event during an idle bus cycle
	task automatic key_event(input logic [7:0] code, input logic pressed);
		bus_cycle(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		key_code_i    <= code;
		key_pressed_i <= pressed;
		key_strobe_i  <= 1'b1;
		@(posedge CLK50MHZ);
		key_strobe_i  <= 1'b0;
	endtask

	task automatic mem_test(input int n);
		logic [31:0] r;
		logic [15:0] a;
		for (int i = 0; i < n; i++)
		begin
			r = xorshift32();
			if (r[1] == 1'b0 || written.size() == 0)
			begin
				a = r[2] ? 16'h7000 + r[31:16] % 16'h0800 : 16'h7800 + r[31:16] % 16'h4000;
				if (r[3] && written.size() > 0)
					a = written[r[31:16] % written.size()];	// Overwrite an old one
				written.push_back(a);
				bus_cycle(a, r[15:8], 1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
			end
			else if (r[0])
			begin
				a = r[2] ? r[31:16] % 16'h6800 : 16'hB800 + r[31:16] % 16'h4800;
				bus_cycle(a, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
			end
			else
				bus_cycle(written[r[31:16] % written.size()], 8'h00, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
		end
	endtask

	task automatic latch_test(input int n);
		logic [31:0] r;
		for (int i = 0; i < n; i++)
		begin
			r = xorshift32();
			if (r[0])
				bus_cycle(16'h6800 + r[31:16] % 16'h0800, r[15:8], 1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
			else
				bus_cycle({r[31:24], r[1] ? 8'(`LB_SHRG_PORT) : r[23:16]}, r[15:8],
					1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
		end
	endtask

	task automatic key_test(input int n);
		logic [31:0] r;
		logic [7:0]  row;
		for (int i = 0; i < n; i++)
		begin
			r = xorshift32();
			key_event(KEY_CODES[(r[15:0] % N_KEYS)*8 +: 8], r[16]);
			r = xorshift32();
			row = r[0] ? ~(8'h01 << r[3:1]) : r[15:8];	// One row or a random mix
			bus_cycle({5'b01101, r[6:4], row}, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0, r[7]);
		end
	endtask

	// Two idle cycles let the checker finish the last real one
	task automatic finish_test(input int num, input string name, input int err_before);
		bus_cycle(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		bus_cycle(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		@(negedge CLK50MHZ);	// Checker updates of this edge are done
		if (errors == err_before && !hung)
			$display("Test %0d %s: passed", num, name);
		else
		begin
			failed_tests++;
			$display("Test %0d %s: failed, %0d errors", num, name, errors - err_before);
		end
	endtask

	initial
	begin
		int e;
		CLK50MHZ = 1'b0;
		RESET_N = 1'b0;
		turbo_i = 1'b0;
		cpu_addr_i = 16'h0000;
		cpu_dout_i = 8'h00;
		cpu_mreq_i = 1'b0;
		cpu_iorq_i = 1'b0;
		cpu_rd_i = 1'b0;
		cpu_wr_i = 1'b0;
		key_strobe_i = 1'b0;
		key_pressed_i = 1'b0;
		key_code_i = 8'h00;
		cass_in_i = 1'b0;
		rng = 32'heea4_4a94;
		hung = 1'b0;
		failed_tests = 0;
		repeat (16) @(posedge CLK50MHZ);
		RESET_N <= 1'b1;

		e = errors;
		for (int r = 0; r < 8; r++)
			bus_cycle({8'h68, ~(8'h01 << r)}, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
		bus_cycle(16'h6800, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
		finish_test(1, "reset state", e);
		e = errors;
		mem_test(150);
		finish_test(2, "RAM and VRAM", e);
		e = errors;
		latch_test(60);
		finish_test(3, "output latch and SHRG", e);
		e = errors;
		key_test(80);
		finish_test(4, "keyboard matrix", e);
		e = errors;
		bus_cycle(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		turbo_i <= 1'b1;
		mem_test(100);
		latch_test(40);
		finish_test(5, "turbo mode", e);

		$display("Tests run 5, failed %0d, checks %0d, errors %0d", failed_tests, checks, errors);
		if (failed_tests == 0 && errors == 0 && !hung)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
